//--- logic/cacheDefines.svh
/*
  Geometry of the four-way read cache. Included by the packages and by
  every module that sizes storage or ports from these values.
*/
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Associativity and set count
`define CACHE_WAYS 4
`define CACHE_INDEX_BITS 4
`define CACHE_SETS (1 << `CACHE_INDEX_BITS)

// 16-byte lines of four words
`define CACHE_OFFSET_BITS 4
`define CACHE_ADDR_BITS 32
`define CACHE_TAG_BITS (`CACHE_ADDR_BITS - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)
`define CACHE_WORD_BITS 32

`endif

//--- logic/cacheAddrPkg.sv
/*
  Address and geometry types shared by the controller, the arrays and
  the replacement policy.
*/
`include "cacheDefines.svh"

package cacheAddrPkg;

  typedef logic [`CACHE_TAG_BITS-1:0]    tag_t;
  typedef logic [`CACHE_INDEX_BITS-1:0]  setIndex_t;
  typedef logic [`CACHE_OFFSET_BITS-1:0] lineOffset_t;

  // One bit per way, at most one set
  typedef logic [`CACHE_WAYS-1:0] wayVec_t;

  // Same address word seen whole or split into its fields
  typedef union packed {
    logic [`CACHE_ADDR_BITS-1:0] raw;
    struct packed {
      tag_t        tag;
      setIndex_t   index;
      lineOffset_t offset;
    } fields;
  } physAddr_u;

endpackage

//--- logic/memBusPkg.sv
/*
  Data types of the requester and line-fill buses, plus the states of
  the cache controller.
*/
`include "cacheDefines.svh"

package memBusPkg;

  typedef logic [`CACHE_WORD_BITS-1:0] word_t;

  // Word 0 sits in the low bits
  typedef logic [3:0][`CACHE_WORD_BITS-1:0] line_t;

  typedef enum logic [1:0] {IDLE, LOOKUP, FILLWAIT, FILLDONE} ctrlState_e;

endpackage

//--- logic/tagArray.sv
/*
  Tag and valid storage for all ways. Read one cycle after the index is
  presented and compared against the tag captured with it.
*/
`timescale 1ns/1ps
`include "cacheDefines.svh"

module tagArray (
  input  logic                 clk,
  input  logic                 reset,
  input  cacheAddrPkg::setIndex_t lookupIndex,
  input  cacheAddrPkg::tag_t      lookupTag,
  input  logic                 fillEn,
  input  cacheAddrPkg::wayVec_t   fillWay,
  input  cacheAddrPkg::setIndex_t fillIndex,
  input  cacheAddrPkg::tag_t      fillTag,
  output cacheAddrPkg::wayVec_t   wayHit
);
  import cacheAddrPkg::*;

  tag_t    tagMem [`CACHE_SETS][`CACHE_WAYS];
  wayVec_t validMem [`CACHE_SETS];

  // Read side registers
  tag_t    tagQ [`CACHE_WAYS];
  tag_t    lookupTagQ;
  wayVec_t validQ;

  ////////////////////
  // Valid bits
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_SETS; s++)
        validMem[s] <= '0;
      validQ <= '0;
    end else begin
      validQ <= validMem[lookupIndex];
      // Fill marks only the victim way
      if (fillEn)
        validMem[fillIndex] <= validMem[fillIndex] | fillWay;
    end
  end

  // Tags themselves
  always_ff @(posedge clk) begin
    lookupTagQ <= lookupTag;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      tagQ[w] <= tagMem[lookupIndex][w];
      if (fillEn && fillWay[w])
        tagMem[fillIndex][w] <= fillTag;
    end
  end

  ////////////////////
  // Hit compare
  ////////////////////
  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++)
      wayHit[w] = validQ[w] && (tagQ[w] == lookupTagQ);
  end

  // A line is never filled while it is still resident in another way
  assert property (@(posedge clk) disable iff (reset) $onehot0(wayHit))
    else $error("tagArray: tag resident in more than one way");

endmodule

//--- logic/pseudoLruPolicy.sv
/*
  Tree pseudo-LRU for 2, 4 or 8 ways. Node bits point toward the victim
  and are updated one cycle after a touch, from the touched way.
*/
`timescale 1ns/1ps
`include "cacheDefines.svh"

module pseudoLruPolicy #(
  parameter int numWays = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  input  cacheAddrPkg::setIndex_t readIndex,
  input  cacheAddrPkg::setIndex_t writeIndex,
  input  logic [numWays-1:0]      lruWay,
  input  logic                    lruWriteEn,
  output logic [numWays-1:0]      victimWay
);
  import cacheAddrPkg::*;

  localparam int levels = $clog2(numWays);

  // Heap order, node 0 is the root and node n has children 2n+1 and 2n+2
  logic [numWays-2:0] treeMem [`CACHE_SETS];
  logic [numWays-2:0] curBits;
  logic [numWays-2:0] nodeEn, nodeMask;
  logic [numWays-2:0] newBits, newBitsQ;
  setIndex_t          readIndexQ, writeIndexQ;
  logic               writeEnQ;

  if (numWays != 2 && numWays != 4 && numWays != 8) begin : badWays
    $error("pseudoLruPolicy supports 2, 4 or 8 ways");
  end

  ////////////////////
  // Tree storage
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_SETS; s++)
        treeMem[s] <= '0;
      readIndexQ <= '0;
      writeEnQ   <= 1'b0;
    end else begin
      readIndexQ <= readIndex;
      writeEnQ   <= lruWriteEn;
      if (writeEnQ)
        treeMem[writeIndexQ] <= newBitsQ;
    end
  end

  // Delayed write data
  always_ff @(posedge clk) begin
    writeIndexQ <= writeIndex;
    newBitsQ    <= newBits;
  end

  assign curBits = treeMem[readIndexQ];

  ////////////////////
  // Victim decode
  ////////////////////
  // A way wins when every node on its path points to its side (1 = right)
  always_comb begin : decodeVictim
    int node;
    for (int w = 0; w < numWays; w++) begin
      victimWay[w] = 1'b1;
      for (int l = 0; l < levels; l++) begin
        node = (1 << l) - 1 + (w >> (levels - l));
        victimWay[w] &= (curBits[node] == 1'((w >> (levels - l - 1)) & 1));
      end
    end
  end

  // Nodes on the touched path turn away from it, others keep old bits
  always_comb begin : touchTree
    int node;
    nodeEn   = '0;
    nodeMask = '0;
    for (int w = 0; w < numWays; w++) begin
      for (int l = 0; l < levels; l++) begin
        node = (1 << l) - 1 + (w >> (levels - l));
        nodeEn[node] |= lruWay[w];
        // Left-side touch sends the victim right
        if (((w >> (levels - l - 1)) & 1) == 0)
          nodeMask[node] |= lruWay[w];
      end
    end
    newBits = (nodeEn & nodeMask) | (~nodeEn & curBits);
  end

  assert property (@(posedge clk) disable iff (reset) $onehot(victimWay))
    else $error("pseudoLruPolicy: victim not one-hot");

  // Controller touches exactly one way per update
  assert property (@(posedge clk) disable iff (reset) lruWriteEn |-> $onehot(lruWay))
    else $error("pseudoLruPolicy: touched way not one-hot");

endmodule

//--- logic/dataArray.sv
/*
  Line storage for all ways. Returns the addressed word of the hit way,
  or of the line just filled so the miss reply needs no second read.
*/
`timescale 1ns/1ps
`include "cacheDefines.svh"

module dataArray (
  input  logic                    clk,
  input  cacheAddrPkg::setIndex_t lookupIndex,
  input  logic [1:0]              wordSel,
  input  cacheAddrPkg::wayVec_t   wayHit,
  input  logic                    fillEn,
  input  cacheAddrPkg::wayVec_t   fillWay,
  input  cacheAddrPkg::setIndex_t fillIndex,
  input  memBusPkg::line_t        fillLine,
  output memBusPkg::word_t        readWord
);
  import memBusPkg::*;

  line_t dataMem [`CACHE_SETS][`CACHE_WAYS];
  line_t lineQ [`CACHE_WAYS];

  // Bypass of the incoming fill word
  logic  fillQ;
  word_t bypassWord;

  always_ff @(posedge clk) begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      lineQ[w] <= dataMem[lookupIndex][w];
      if (fillEn && fillWay[w])
        dataMem[fillIndex][w] <= fillLine;
    end
    fillQ      <= fillEn;
    bypassWord <= fillLine[wordSel];
  end

  // wayHit is one-hot or zero so OR-ing the ways is a mux
  always_comb begin
    readWord = '0;
    for (int w = 0; w < `CACHE_WAYS; w++)
      if (wayHit[w])
        readWord |= lineQ[w][wordSel];
    if (fillQ)
      readWord = bypassWord;
  end

endmodule

//--- logic/cacheController.sv
/*
  Sequences lookup, miss request and fill for one request at a time.
  Drives the array indices, the fill and LRU touches and both strobes.
*/
`timescale 1ns/1ps
`include "cacheDefines.svh"

module cacheController (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    reqValid,
  input  cacheAddrPkg::physAddr_u reqAddr,
  input  cacheAddrPkg::wayVec_t   wayHit,
  input  cacheAddrPkg::wayVec_t   victimWay,
  input  logic                    memRespValid,
  output cacheAddrPkg::setIndex_t lookupIndex,
  output cacheAddrPkg::setIndex_t fillIndex,
  output cacheAddrPkg::tag_t      lookupTag,
  output cacheAddrPkg::tag_t      fillTag,
  output logic [1:0]              wordSel,
  output logic                    fillEn,
  output cacheAddrPkg::wayVec_t   fillWay,
  output logic                    lruWriteEn,
  output cacheAddrPkg::wayVec_t   lruWay,
  output logic                    memReqValid,
  output cacheAddrPkg::physAddr_u memReqAddr,
  output logic                    respValid
);
  import cacheAddrPkg::*;
  import memBusPkg::*;

  ctrlState_e state;
  physAddr_u  addrQ, lookAddr;
  wayVec_t    victimQ;
  logic       anyHit;

  ////////////////////
  // State machine
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= IDLE;
      addrQ       <= '0;
      memReqValid <= 1'b0;
      respValid   <= 1'b0;
    end else begin
      // Both strobes are single-cycle pulses
      memReqValid <= 1'b0;
      respValid   <= 1'b0;
      case (state)
        IDLE: if (reqValid) begin
          addrQ <= reqAddr;
          state <= LOOKUP;
        end
        LOOKUP: if (anyHit) begin
          respValid <= 1'b1;
          state     <= IDLE;
        end else begin
          memReqValid <= 1'b1;
          state       <= FILLWAIT;
        end
        FILLWAIT: if (memRespValid) begin
          respValid <= 1'b1;
          state     <= FILLDONE;
        end
        // Response cycle, word comes from the fill bypass
        FILLDONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Victim held for the whole miss
  always_ff @(posedge clk)
    if (state == LOOKUP && !anyHit)
      victimQ <= victimWay;

  // New request goes straight to the arrays, otherwise hold the latched one
  assign lookAddr    = (state == IDLE && reqValid) ? reqAddr : addrQ;
  assign lookupIndex = lookAddr.fields.index;
  assign lookupTag   = lookAddr.fields.tag;
  assign anyHit      = |wayHit;

  ////////////////////
  // Fill and LRU touch
  ////////////////////
  assign fillEn     = (state == FILLWAIT) && memRespValid;
  assign fillWay    = victimQ;
  assign fillIndex  = addrQ.fields.index;
  assign fillTag    = addrQ.fields.tag;
  assign wordSel    = addrQ.fields.offset[`CACHE_OFFSET_BITS-1 -: 2];
  assign lruWriteEn = (state == LOOKUP && anyHit) || fillEn;
  assign lruWay     = fillEn ? victimQ : wayHit;

  // Line-aligned fill address
  always_comb begin
    memReqAddr              = addrQ;
    memReqAddr.fields.offset = '0;
  end

  // Requester keeps one request outstanding
  assert property (@(posedge clk) disable iff (reset) reqValid |-> state == IDLE)
    else $error("cacheController: request while busy");

endmodule

//--- logic/cacheTop.sv
/*
  Read cache top level. Joins the controller, tag and data arrays and
  the pseudo-LRU to the requester and line-fill ports.
*/
`timescale 1ns/1ps
`include "cacheDefines.svh"

module cacheTop (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    reqValid,
  input  cacheAddrPkg::physAddr_u reqAddr,
  output logic                    respValid,
  output memBusPkg::word_t        respData,
  output logic                    memReqValid,
  output cacheAddrPkg::physAddr_u memReqAddr,
  input  logic                    memRespValid,
  input  memBusPkg::line_t        memRespLine
);
  import cacheAddrPkg::*;

  setIndex_t  lookupIndex, fillIndex;
  tag_t       lookupTag, fillTag;
  logic [1:0] wordSel;
  logic       fillEn, lruWriteEn;
  wayVec_t    wayHit, victimWay, fillWay, lruWay;

  cacheController ctrl0 (
    .clk, .reset, .reqValid, .reqAddr, .wayHit, .victimWay, .memRespValid,
    .lookupIndex, .fillIndex, .lookupTag, .fillTag, .wordSel, .fillEn,
    .fillWay, .lruWriteEn, .lruWay, .memReqValid, .memReqAddr, .respValid
  );

  tagArray tags0 (
    .clk, .reset, .lookupIndex, .lookupTag, .fillEn, .fillWay, .fillIndex,
    .fillTag, .wayHit
  );

  // Tree write goes to the set held by the controller
  pseudoLruPolicy #(.numWays(`CACHE_WAYS)) lru0 (
    .clk, .reset, .readIndex(lookupIndex), .writeIndex(fillIndex), .lruWay,
    .lruWriteEn, .victimWay
  );

  dataArray data0 (
    .clk, .lookupIndex, .wordSel, .wayHit, .fillEn, .fillWay, .fillIndex,
    .fillLine(memRespLine), .readWord(respData)
  );

endmodule

//--- verification/lineMemory.sv
/*
  Behavioural line-fill memory for the cache testbench. Answers each
  line request after 1 to 6 cycles with data computed from the address.
*/
`timescale 1ns/1ps

module lineMemory #(
  parameter int seedInit = 32'h70b0_59c8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             memReqValid,
  input  logic [31:0]      memReqAddr,
  output logic             memRespValid,
  output logic [3:0][31:0] memRespLine
);
  int seed = seedInit;

  // Word k of the line at lineAddr
  function automatic logic [31:0] mixWord(input logic [31:0] lineAddr, input int k);
    return ({lineAddr[31:4], 2'(k), 2'b01} * 32'h9e37_79b1) ^ (32'h5bd1_e995 >> k);
  endfunction

  // Requests seen mid-cycle, answer driven on a falling edge
  initial begin : answerRequests
    logic [31:0] lineAddr;
    int delay;
    memRespValid = 1'b0;
    memRespLine  = '0;
    forever begin
      @(negedge clk);
      if (memReqValid && !reset) begin
        lineAddr = memReqAddr;
        delay    = 1 + ({$random(seed)} % 6);
        repeat (delay) @(negedge clk);
        for (int k = 0; k < 4; k++)
          memRespLine[k] = mixWord(lineAddr, k);
        memRespValid = 1'b1;
        @(negedge clk);
        memRespValid = 1'b0;
      end
    end
  end

endmodule

//--- verification/cacheTb.sv
/*
  Testbench for the four-way read cache. Runs directed and random reads
  against a tag and tree pseudo-LRU model, concurrent assertions check.
*/
`timescale 1ns/1ps

module cacheTb;

  localparam int numRequests = 260;
  // Worst request with gaps is well under 20 cycles
  localparam longint timeoutNs = (16 + numRequests * 20) * 20;

  logic             clk;
  logic             reset;
  logic             reqValid;
  logic [31:0]      reqAddr;
  logic             respValid;
  logic [31:0]      respData;
  logic             memReqValid;
  logic [31:0]      memReqAddr;
  logic             memRespValid;
  logic [3:0][31:0] memRespLine;

  int seed = 32'h70b0_59c8;
  int dataErrors = 0;
  int protoErrors = 0;

  // Expectation of the request in flight
  logic        expMiss = 1'b0;
  logic [31:0] expData = '0;
  logic [31:0] expLine = '0;
  logic        pending;
  logic        rstQ = 1'b0;

  // Reference model, tree bit 0 is the root, 1 and 2 the way pairs
  logic [23:0] refTag [16][4];
  logic        refValid [16][4];
  logic [2:0]  refTree [16];

  cacheTop dut0 (
    .clk, .reset, .reqValid, .reqAddr, .respValid, .respData,
    .memReqValid, .memReqAddr, .memRespValid, .memRespLine
  );

  lineMemory mem0 (
    .clk, .reset, .memReqValid, .memReqAddr, .memRespValid, .memRespLine
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always_ff @(posedge clk) begin
    rstQ <= reset;
    if (reset)
      pending <= 1'b0;
    else if (reqValid)
      pending <= 1'b1;
    else if (respValid)
      pending <= 1'b0;
  end

  function automatic logic [31:0] mixWord(input logic [31:0] lineAddr, input int k);
    return ({lineAddr[31:4], 2'(k), 2'b01} * 32'h9e37_79b1) ^ (32'h5bd1_e995 >> k);
  endfunction

  // Nodes on the path point away from the touched way
  function automatic void touchWay(input int set, input int way);
    refTree[set][0] = (way < 2);
    if (way < 2)
      refTree[set][1] = (way == 0);
    else
      refTree[set][2] = (way == 2);
  endfunction

  function automatic void predictAccess(input logic [31:0] addr);
    logic [23:0] tag;
    int set;
    int way;
    tag = addr[31:8];
    set = addr[7:4];
    way = -1;
    for (int w = 0; w < 4; w++)
      if (refValid[set][w] && refTag[set][w] == tag)
        way = w;
    expMiss = (way < 0);
    if (expMiss) begin
      // Victim follows the tree, valid bits play no part
      if (!refTree[set][0])
        way = refTree[set][1] ? 1 : 0;
      else
        way = refTree[set][2] ? 3 : 2;
      refTag[set][way] = tag;
      refValid[set][way] = 1'b1;
    end
    touchWay(set, way);
    expLine = {addr[31:4], 4'b0};
    expData = mixWord(expLine, addr[3:2]);
  endfunction

  // Called on a falling edge, returns on one
  task automatic sendRequest(input logic [31:0] addr);
    predictAccess(addr);
    reqAddr  = addr;
    reqValid = 1'b1;
    @(negedge clk);
    reqValid = 1'b0;
    while (!respValid)
      @(negedge clk);
    // Gap for FILLDONE and the delayed tree write
    @(negedge clk);
  endtask

  ////////////////////
  // Checks
  ////////////////////
  dataCheck: assert property (@(posedge clk) disable iff (reset)
    respValid |-> respData == expData)
    else begin
      dataErrors++;
      $display("FAIL %0t respData got %h expected %h", $time,
        $sampled(respData), $sampled(expData));
    end

  lineAddrCheck: assert property (@(posedge clk) disable iff (reset)
    memReqValid |-> memReqAddr == expLine)
    else begin
      protoErrors++;
      $display("FAIL %0t memReqAddr got %h expected %h", $time,
        $sampled(memReqAddr), $sampled(expLine));
    end

  noFetchOnHit: assert property (@(posedge clk) disable iff (reset) memReqValid |-> expMiss)
    else begin
      protoErrors++;
      $display("%0t: line fetched for an access the model calls a hit", $time);
    end

  missFetches: assert property (@(posedge clk) disable iff (reset)
    reqValid && expMiss |-> ##2 memReqValid)
    else begin
      protoErrors++;
      $display("%0t: no line fetch for an access the model calls a miss", $time);
    end

  hitLatency: assert property (@(posedge clk) disable iff (reset)
    reqValid && !expMiss |=> !respValid ##1 respValid)
    else begin
      protoErrors++;
      $display("%0t: hit response not exactly two cycles after request", $time);
    end

  oneResponse: assert property (@(posedge clk) disable iff (reset) respValid |-> pending)
    else begin
      protoErrors++;
      $display("%0t: response without an open request", $time);
    end

  quietReset: assert property (@(posedge clk) rstQ |-> !respValid && !memReqValid)
    else begin
      protoErrors++;
      $display("%0t: strobe raised during or right after reset", $time);
    end

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    reset    = 1'b1;
    reqValid = 1'b0;
    reqAddr  = '0;
    for (int s = 0; s < 16; s++) begin
      refTree[s] = '0;
      for (int w = 0; w < 4; w++)
        refValid[s][w] = 1'b0;
    end
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // First access to each line, then repeats of the same lines
    for (int pass = 0; pass < 2; pass++)
      for (int s = 0; s < 8; s++)
        for (int t = 0; t < 2; t++)
          sendRequest({24'h0012_00 + 24'(t), 4'(s), 2'(s + t), 2'b00});

    // Six tags through one set force evictions
    begin : evictionOrder
      int order[12];
      order = '{1, 2, 3, 4, 5, 1, 3, 6, 2, 4, 1, 5};
      for (int i = 0; i < 12; i++)
        sendRequest({24'h0034_00 + 24'(order[i]), 4'd5, 2'(i), 2'b00});
    end

    // Mixed traffic over a few tags and sets
    repeat (200) begin
      sendRequest({24'h0056_00 + 24'({$random(seed)} % 6), 4'({$random(seed)} % 4),
        2'($random(seed)), 2'b00});
    end

    repeat (4) @(negedge clk);
    $display("Errors: data %0d, protocol %0d", dataErrors, protoErrors);
    if (dataErrors + protoErrors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Stops a run whose DUT stopped answering
  initial begin
    #(timeoutNs);
    $display("Watchdog expired before all requests got a response");
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- build.f
+incdir+logic
logic/cacheAddrPkg.sv
logic/memBusPkg.sv
logic/tagArray.sv
logic/pseudoLruPolicy.sv
logic/dataArray.sv
logic/cacheController.sv
logic/cacheTop.sv
verification/lineMemory.sv
verification/cacheTb.sv

//--- Makefile
SIM      = verilator
TOP      = cacheTb
FILELIST = build.f
FLAGS    = --binary --timing --assert -Wno-fatal --timescale 1ns/1ps --top-module $(TOP)
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) logic/cacheDefines.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

# The log decides pass or fail
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
